/* alu.sv */
`timescale 1ns/1ps

module alu (
   input  logic                    clock,
   input  logic                    reset,
   input  cpu_types_pkg::instr_t   ir,
   input  logic                    execute,
   input  cpu_types_pkg::word_t    src_value,
   input  cpu_types_pkg::word_t    operand,
   output cpu_types_pkg::word_t    result,
   output logic                    write_en,
   output cpu_types_pkg::reg_sel_t dst_sel
);

   logic            cf;
   logic [2:0]      df;
   logic [3:0]      ff_code;
   isa_pkg::func_t  func;
   logic            func_writes;
   logic            dest_writes;
   logic            cmp_valid;
   logic            cmp_hit;
   logic            b; // compare flag.

   assign cf      = ir[isa_pkg::CF_BIT];
   assign df      = ir[isa_pkg::DF_MSB:isa_pkg::DF_LSB];
   assign ff_code = ir[isa_pkg::FF_MSB:isa_pkg::FF_LSB];
   assign func    = isa_pkg::func_t'(ff_code);

   // ==============================
   // arithmetic
   // ==============================
   always_comb
   begin
      result      = '0;
      func_writes = 1'b1;
      case (func)
         isa_pkg::func_neg:                       result = '0 - operand;
         isa_pkg::func_mov_a, isa_pkg::func_mov_b: result = operand;
         isa_pkg::func_add_a, isa_pkg::func_add_b: result = src_value + operand;
         isa_pkg::func_sub_a, isa_pkg::func_sub_b: result = src_value - operand;
         default:                                 func_writes = 1'b0; // 1 and 8 to 15.
      endcase
   end

   // jumps write register 3 depending on b; store and 6 write nothing.
   always_comb
   begin
      dst_sel     = df[1:0];
      dest_writes = 1'b0;
      if (df <= isa_pkg::DEST_REG_MAX)
         dest_writes = 1'b1;
      else if (df == isa_pkg::DEST_JUMP_SET)
      begin
         dst_sel     = isa_pkg::PC_REG;
         dest_writes = b;
      end
      else if (df == isa_pkg::DEST_JUMP_CLEAR)
      begin
         dst_sel     = isa_pkg::PC_REG;
         dest_writes = !b;
      end
   end

   assign write_en = execute && !cf && func_writes && dest_writes;

   // ==============================
   // compare
   // ==============================
   always_comb
   begin
      cmp_valid = 1'b1;
      cmp_hit   = 1'b0;
      case (ff_code)
         isa_pkg::CMP_LT: cmp_hit = src_value < operand;
         isa_pkg::CMP_GE: cmp_hit = src_value >= operand;
         isa_pkg::CMP_EQ: cmp_hit = src_value == operand;
         isa_pkg::CMP_NE: cmp_hit = src_value != operand;
         isa_pkg::CMP_LE: cmp_hit = src_value <= operand;
         isa_pkg::CMP_GT: cmp_hit = src_value > operand;
         default:         cmp_valid = 1'b0; // b keeps its value.
      endcase
   end

   always_ff @(posedge clock or posedge reset)
   begin
      if (reset)
         b <= 1'b0;
      else if (execute && cf && cmp_valid)
         b <= cmp_hit;
   end

endmodule

/* b14_cases.txt */
# case <name> | mem <addr> <word> | read <addr> in order | store <addr> <value>
# all numbers hex, addresses are 20-bit word addresses
case imm_move_store
mem 00000 00112345
mem 00008 0F000040
mem 00010 6F000044
read 00000
read 00008
read 00010
store 00040 00012345
store 00044 00000018
case direct_arith
mem 00000 09100100
mem 00008 29200101
mem 00010 2F000200
mem 00018 0A000102
mem 00020 4F000201
mem 00028 08300103
mem 00030 0F000202
mem 00100 3FFFFFFE
mem 00101 00000005
mem 00102 00000001
mem 00103 00000002
read 00000
read 00100
read 00008
read 00101
read 00010
read 00018
read 00102
read 00020
read 00028
read 00103
read 00030
store 00200 00000003
store 00201 3FFFFFFF
store 00202 3FFFFFFE
case indexed
mem 00000 01100010
mem 00008 021FFFF0
mem 00010 10100300
mem 00018 1F000050
mem 00020 18100420
mem 00028 17000070
mem 00310 000ABCDE
mem 00410 00001234
read 00000
read 00008
read 00010
read 00310
read 00018
read 00020
read 00410
read 00028
store 00040 000ABCDE
store 00080 00001234
case compare_jump
mem 00000 00100007
mem 00008 00800009
mem 00010 04100040
mem 00018 0F000301
mem 00040 0F000300
mem 00048 00900007
mem 00050 05100080
mem 00058 6F000301
mem 00060 00A80007
mem 00068 051000C0
mem 000C0 0F000302
read 00000
read 00008
read 00010
read 00040
read 00048
read 00050
read 00058
read 00060
read 00068
read 000C0
store 00300 00000007
store 00301 00000060
store 00302 00000007

/* b14_top.sv */
`timescale 1ns/1ps

module b14_top (
   input  logic                 clock,
   input  logic                 reset,
   input  cpu_types_pkg::bus_t  datai,
   output cpu_types_pkg::addr_t addr,
   output cpu_types_pkg::bus_t  datao,
   output logic                 rd,
   output logic                 wr
);

   cpu_types_pkg::instr_t   ir;
   logic                    fetch_done;
   logic                    execute;
   cpu_types_pkg::word_t    pc;
   cpu_types_pkg::word_t    src_value;
   cpu_types_pkg::word_t    reg1;
   cpu_types_pkg::word_t    reg2;
   cpu_types_pkg::addr_t    eff_addr;
   cpu_types_pkg::word_t    operand;
   cpu_types_pkg::word_t    result;
   logic                    write_en;
   cpu_types_pkg::reg_sel_t dst_sel;

   // ==============================
   // control and memory side
   // ==============================
   sequencer u_seq (
      .clock      (clock),
      .reset      (reset),
      .datai      (datai),
      .eff_addr   (eff_addr),
      .pc         (pc),
      .src_value  (src_value),
      .ir         (ir),
      .fetch_done (fetch_done),
      .execute    (execute),
      .addr       (addr),
      .rd         (rd),
      .wr         (wr),
      .datao      (datao)
   );

   // ==============================
   // datapath
   // ==============================
   program_counter u_pc (
      .clock      (clock),
      .reset      (reset),
      .fetch_done (fetch_done),
      .write_en   (write_en),
      .dst_sel    (dst_sel),
      .result     (result),
      .pc         (pc)
   );

   register_file u_regs (
      .clock     (clock),
      .reset     (reset),
      .ir        (ir),
      .pc        (pc),
      .write_en  (write_en),
      .dst_sel   (dst_sel),
      .result    (result),
      .src_value (src_value),
      .reg1      (reg1),
      .reg2      (reg2)
   );

   operand_unit u_opnd (
      .ir       (ir),
      .datai    (datai),
      .reg1     (reg1),
      .reg2     (reg2),
      .eff_addr (eff_addr),
      .operand  (operand)
   );

   alu u_alu (
      .clock     (clock),
      .reset     (reset),
      .ir        (ir),
      .execute   (execute),
      .src_value (src_value),
      .operand   (operand),
      .result    (result),
      .write_en  (write_en),
      .dst_sel   (dst_sel)
   );

endmodule

/* cpu_types_pkg.sv */
package cpu_types_pkg;

   // ==============================
   // widths
   // ==============================
   localparam int WORD_WIDTH    = 30; // register and arithmetic width.
   localparam int ADDR_WIDTH    = 20; // memory word address.
   localparam int BUS_WIDTH     = 32;
   localparam int REG_SEL_WIDTH = 2;

   // ==============================
   // vector types
   // ==============================
   typedef logic [WORD_WIDTH-1:0]    word_t;
   typedef logic [ADDR_WIDTH-1:0]    addr_t;

   // datai and datao.
   typedef logic [BUS_WIDTH-1:0]     bus_t;
   typedef logic [BUS_WIDTH-1:0]     instr_t; // instructions arrive over the bus.

   typedef logic [REG_SEL_WIDTH-1:0] reg_sel_t;

endpackage

/* filelist.f */
cpu_types_pkg.sv
isa_pkg.sv
program_counter.sv
register_file.sv
operand_unit.sv
alu.sv
sequencer.sv
b14_top.sv
tb_b14.sv

/* isa_pkg.sv */
package isa_pkg;

   // ==============================
   // instruction fields
   // ==============================
   localparam int S_MSB    = 30; // source register.
   localparam int S_LSB    = 29;
   localparam int MF_MSB   = 28; // addressing mode.
   localparam int MF_LSB   = 27;
   localparam int DF_MSB   = 26; // destination.
   localparam int DF_LSB   = 24;
   localparam int CF_BIT   = 23; // compare when set.
   localparam int FF_MSB   = 22; // function.
   localparam int FF_LSB   = 19;
   localparam int TAIL_MSB = 19; // shares bit 19 with the function field.
   localparam int TAIL_LSB = 0;

   // ==============================
   // codes
   // ==============================
   typedef enum logic [1:0] {
      mode_imm    = 2'd0,
      mode_direct = 2'd1,
      mode_idx1   = 2'd2,
      mode_idx2   = 2'd3
   } mode_t;

   // code 1 was the old exchange and is no longer decoded.
   typedef enum logic [3:0] {
      func_neg   = 4'd0,
      func_mov_a = 4'd2,
      func_mov_b = 4'd3,
      func_add_a = 4'd4,
      func_add_b = 4'd5,
      func_sub_a = 4'd6,
      func_sub_b = 4'd7
   } func_t;

   // compare functions that set flag b.
   localparam logic [3:0] CMP_LT = 4'd0;
   localparam logic [3:0] CMP_GE = 4'd1;
   localparam logic [3:0] CMP_EQ = 4'd2;
   localparam logic [3:0] CMP_NE = 4'd3;
   localparam logic [3:0] CMP_LE = 4'd4;
   localparam logic [3:0] CMP_GT = 4'd5;

   localparam logic [2:0] DEST_REG_MAX    = 3'd3; // 0 to 3 name a register.
   localparam logic [2:0] DEST_JUMP_SET   = 3'd4;
   localparam logic [2:0] DEST_JUMP_CLEAR = 3'd5;
   localparam logic [2:0] DEST_STORE      = 3'd7;

   localparam cpu_types_pkg::reg_sel_t PC_REG  = 2'd3;
   localparam cpu_types_pkg::word_t    PC_STEP = 30'd8;
   localparam int                      PC_WRAP_BITS = 29;

endpackage

/* operand_unit.sv */
`timescale 1ns/1ps

module operand_unit (
   input  cpu_types_pkg::instr_t ir,
   input  cpu_types_pkg::bus_t   datai,
   input  cpu_types_pkg::word_t  reg1,
   input  cpu_types_pkg::word_t  reg2,
   output cpu_types_pkg::addr_t  eff_addr,
   output cpu_types_pkg::word_t  operand
);

   cpu_types_pkg::addr_t tail;
   isa_pkg::mode_t       mode;

   assign tail = ir[isa_pkg::TAIL_MSB:isa_pkg::TAIL_LSB];
   assign mode = isa_pkg::mode_t'(ir[isa_pkg::MF_MSB:isa_pkg::MF_LSB]);

   // ==============================
   // effective address
   // ==============================
   // sums drop the carry out of bit 19.
   always_comb
   begin
      case (mode)
         isa_pkg::mode_idx1: eff_addr = tail + reg1[cpu_types_pkg::ADDR_WIDTH-1:0];
         isa_pkg::mode_idx2: eff_addr = tail + reg2[cpu_types_pkg::ADDR_WIDTH-1:0];
         default:            eff_addr = tail; // immediate and direct.
      endcase
   end

   // ==============================
   // operand value
   // ==============================
   // memory modes take the word read in the cycle before execute.
   always_comb
   begin
      if (mode == isa_pkg::mode_imm)
         operand = cpu_types_pkg::word_t'(tail);
      else
         operand = datai[cpu_types_pkg::WORD_WIDTH-1:0];
   end

endmodule

/* program_counter.sv */
`timescale 1ns/1ps

module program_counter (
   input  logic                    clock,
   input  logic                    reset,
   input  logic                    fetch_done,
   input  logic                    write_en,
   input  cpu_types_pkg::reg_sel_t dst_sel,
   input  cpu_types_pkg::word_t    result,
   output cpu_types_pkg::word_t    pc
);

   cpu_types_pkg::word_t pc_stepped;

   // wraps at 2^29 before the step, so the top bit only comes from a load.
   assign pc_stepped = cpu_types_pkg::word_t'(pc[isa_pkg::PC_WRAP_BITS-1:0]) + isa_pkg::PC_STEP;

   always_ff @(posedge clock or posedge reset)
   begin
      if (reset)
         pc <= '0;
      else if (write_en && (dst_sel == isa_pkg::PC_REG))
         pc <= result;     // jump or direct write in execute.
      else if (fetch_done)
         pc <= pc_stepped; // decode cycle.
   end

endmodule

/* register_file.sv */
`timescale 1ns/1ps

module register_file (
   input  logic                    clock,
   input  logic                    reset,
   input  cpu_types_pkg::instr_t   ir,
   input  cpu_types_pkg::word_t    pc,
   input  logic                    write_en,
   input  cpu_types_pkg::reg_sel_t dst_sel,
   input  cpu_types_pkg::word_t    result,
   output cpu_types_pkg::word_t    src_value,
   output cpu_types_pkg::word_t    reg1,
   output cpu_types_pkg::word_t    reg2
);

   cpu_types_pkg::word_t     regs [0:2]; // register 3 lives in program_counter.
   cpu_types_pkg::reg_sel_t  src_sel;

   assign src_sel = ir[isa_pkg::S_MSB:isa_pkg::S_LSB];
   assign reg1    = regs[1];
   assign reg2    = regs[2];

   always_ff @(posedge clock or posedge reset)
   begin
      if (reset)
      begin
         regs[0] <= '0;
         regs[1] <= '0;
         regs[2] <= '0;
      end
      else if (write_en && (dst_sel != isa_pkg::PC_REG))
         regs[dst_sel] <= result;
   end

   always_comb
   begin
      case (src_sel)
         2'd0:    src_value = regs[0];
         2'd1:    src_value = regs[1];
         2'd2:    src_value = regs[2];
         default: src_value = pc; // s = 3.
      endcase
   end

endmodule

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_b14 -o Vtb_b14
status=$?
if [ $status -ne 0 ]; then
   echo "build failed"
   exit $status
fi

./obj_dir/Vtb_b14
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed"
   exit $status
fi
exit 0

/* sequencer.sv */
`timescale 1ns/1ps

module sequencer (
   input  logic                  clock,
   input  logic                  reset,
   input  cpu_types_pkg::bus_t   datai,
   input  cpu_types_pkg::addr_t  eff_addr,
   input  cpu_types_pkg::word_t  pc,
   input  cpu_types_pkg::word_t  src_value,
   output cpu_types_pkg::instr_t ir,
   output logic                  fetch_done,
   output logic                  execute,
   output cpu_types_pkg::addr_t  addr,
   output logic                  rd,
   output logic                  wr,
   output cpu_types_pkg::bus_t   datao
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_FETCH,
      S_DECODE,
      S_OPERAND,
      S_EXECUTE
   } state_t;

   state_t          state;
   state_t          next_state;
   isa_pkg::mode_t  new_mode;
   logic            new_store;
   logic            need_operand;

   assign fetch_done = (state == S_DECODE);
   assign execute    = (state == S_EXECUTE);

   // ==============================
   // decode of the fetched word
   // ==============================
   // the word is still on datai here and ir loads at the end of decode.
   always_comb
   begin
      new_mode     = isa_pkg::mode_t'(datai[isa_pkg::MF_MSB:isa_pkg::MF_LSB]);
      new_store    = !datai[isa_pkg::CF_BIT] &&
                     (datai[isa_pkg::DF_MSB:isa_pkg::DF_LSB] == isa_pkg::DEST_STORE);
      need_operand = (new_mode != isa_pkg::mode_imm) && !new_store;
   end

   always_comb
   begin
      case (state)
         S_IDLE:    next_state = S_FETCH;
         S_FETCH:   next_state = S_DECODE;
         S_DECODE:  next_state = need_operand ? S_OPERAND : S_EXECUTE;
         S_OPERAND: next_state = S_EXECUTE;
         default:   next_state = S_FETCH; // execute.
      endcase
   end

   // ==============================
   // state and strobes
   // ==============================
   always_ff @(posedge clock or posedge reset)
   begin
      if (reset)
      begin
         state <= S_IDLE;
         rd    <= 1'b0;
         wr    <= 1'b0;
      end
      else
      begin
         state <= next_state;
         rd    <= (next_state == S_FETCH) || (next_state == S_OPERAND);
         wr    <= (state == S_DECODE) && new_store; // high for the store's execute.
      end
   end

   always_ff @(posedge clock or posedge reset)
   begin
      if (reset)
         ir <= '0;
      else if (state == S_DECODE)
         ir <= datai;
   end

   // fetch takes the pc register itself,
   // so a jump loaded at the end of execute is fetched at once.
   always_comb
   begin
      if (state == S_FETCH)
         addr = pc[cpu_types_pkg::ADDR_WIDTH-1:0];
      else if (rd || wr)
         addr = eff_addr; // operand read or store.
      else
         addr = '0;
   end

   // stored value sees register 3 after the step.
   assign datao = wr ? cpu_types_pkg::bus_t'(src_value) : '0;

endmodule

/* tb_b14.sv */
`timescale 1ns/1ps

module tb_b14;

   logic                 clock;
   logic                 reset;
   cpu_types_pkg::bus_t  datai;
   cpu_types_pkg::addr_t addr;
   cpu_types_pkg::bus_t  datao;
   logic                 rd;
   logic                 wr;

   // one entry per line of the data file.
   string                case_names [$];
   int                   mem_case   [$];
   cpu_types_pkg::addr_t mem_addr   [$];
   cpu_types_pkg::bus_t  mem_data   [$];
   int                   st_case    [$];
   cpu_types_pkg::addr_t st_addr    [$];
   cpu_types_pkg::word_t st_val     [$];
   int                   rd_case    [$];
   cpu_types_pkg::addr_t rd_addr    [$];

   // state of the running case.
   cpu_types_pkg::bus_t  mem [cpu_types_pkg::addr_t];
   cpu_types_pkg::addr_t exp_rd      [$];
   cpu_types_pkg::addr_t exp_st_addr [$];
   cpu_types_pkg::word_t exp_st_val  [$];
   string                cur_name;
   logic                 active;
   logic                 loaded;
   int                   stores_seen;

   b14_top dut0 (
      .clock (clock),
      .reset (reset),
      .datai (datai),
      .addr  (addr),
      .datao (datao),
      .rd    (rd),
      .wr    (wr)
   );

   initial
   begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   // ==============================
   // helpers
   // ==============================
   function automatic logic [31:0] lcg_next(logic [31:0] x);
      return x * 32'd1103515245 + 32'd12345;
   endfunction

   // unset words hold function 1 to destination 6 and write nothing.
   function automatic cpu_types_pkg::bus_t filler(cpu_types_pkg::addr_t a);
      logic [31:0] r;
      r = lcg_next(lcg_next(32'd10 ^ {12'd0, a}));
      return (r & 32'h7807_FFFF) | 32'h0608_0000;
   endfunction

   function automatic cpu_types_pkg::bus_t read_word(cpu_types_pkg::addr_t a);
      if (mem.exists(a))
         return mem[a];
      else
         return filler(a);
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_addr(input string name, input cpu_types_pkg::addr_t expected,
                             input cpu_types_pkg::addr_t actual);
      if (expected !== actual)
         report_failure($sformatf("[FAIL] %s: address expected %h, actual %h",
                                  name, expected, actual));
   endtask

   task automatic check_word(input string name, input cpu_types_pkg::word_t expected,
                             input cpu_types_pkg::word_t actual);
      if (expected !== actual)
         report_failure($sformatf("[FAIL] %s: value expected %h, actual %h",
                                  name, expected, actual));
   endtask

   task automatic load_cases();
      int          fd;
      int          ci;
      string       line;
      string       tag;
      string       name;
      logic [31:0] a;
      logic [31:0] d;
      byte         c;
      fd = $fopen("b14_cases.txt", "r");
      ci = -1;
      if (fd == 0)
         report_failure("could not open b14_cases.txt");
      while (!$feof(fd))
      begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2)
            continue;
         c = line.getc(0);
         a = '0;
         d = '0;
         case (c)
            "c":
            begin
               void'($sscanf(line, "%s %s", tag, name));
               case_names.push_back(name);
               ci = case_names.size() - 1;
            end
            "m":
            begin
               void'($sscanf(line, "%s %h %h", tag, a, d));
               mem_case.push_back(ci);
               mem_addr.push_back(a[19:0]);
               mem_data.push_back(d);
            end
            "s":
            begin
               void'($sscanf(line, "%s %h %h", tag, a, d));
               st_case.push_back(ci);
               st_addr.push_back(a[19:0]);
               st_val.push_back(d[29:0]);
            end
            "r":
            begin
               void'($sscanf(line, "%s %h", tag, a));
               rd_case.push_back(ci);
               rd_addr.push_back(a[19:0]);
            end
            default: ; // comment or blank.
         endcase
      end
      $fclose(fd);
   endtask

   // ==============================
   // memory model and bus checks
   // ==============================
   always @(posedge clock)
   begin
      if (rd && wr)
         report_failure("rd and wr were high in the same cycle");
      if (active && rd)
      begin
         if (exp_rd.size() > 0)
            check_addr(cur_name, exp_rd.pop_front(), addr);
         else if (exp_st_addr.size() > 0)
            report_failure($sformatf("case %s read address %h that was not listed",
                                     cur_name, addr));
         datai <= read_word(addr); // valid in the next cycle.
      end
      if (active && wr)
      begin
         if (exp_st_addr.size() == 0)
            report_failure($sformatf("case %s made a store that was not expected", cur_name));
         check_addr(cur_name, exp_st_addr.pop_front(), addr);
         check_word(cur_name, exp_st_val.pop_front(), datao[29:0]);
         mem[addr] = {2'b00, datao[29:0]};
         stores_seen = stores_seen + 1;
      end
   end

   // ==============================
   // watchdog
   // ==============================
   initial
   begin
      longint limit;
      wait (loaded);
      limit = longint'(st_case.size()) * 32 * 4 * 20; // stores x instructions x cycles x ns.
      #(limit);
      report_failure("watchdog expired before all expected stores arrived");
   end

   // ==============================
   // case runner
   // ==============================
   initial
   begin
      int expected;
      reset       = 1'b1;
      datai       = '0;
      active      = 1'b0;
      loaded      = 1'b0;
      stores_seen = 0;
      load_cases();
      if (st_case.size() == 0)
         report_failure("b14_cases.txt holds no expected stores");
      loaded = 1'b1;
      for (int i = 0; i < case_names.size(); i++)
      begin
         @(posedge clock);
         active <= 1'b0;
         reset  <= 1'b1;
         cur_name = case_names[i];
         mem.delete();
         exp_rd.delete();
         exp_st_addr.delete();
         exp_st_val.delete();
         expected = 0;
         for (int k = 0; k < mem_case.size(); k++)
            if (mem_case[k] == i)
               mem[mem_addr[k]] = mem_data[k];
         for (int k = 0; k < rd_case.size(); k++)
            if (rd_case[k] == i)
               exp_rd.push_back(rd_addr[k]);
         for (int k = 0; k < st_case.size(); k++)
         begin
            if (st_case[k] == i)
            begin
               exp_st_addr.push_back(st_addr[k]);
               exp_st_val.push_back(st_val[k]);
               expected++;
            end
         end
         stores_seen = 0;
         repeat (8)
         begin
            @(posedge clock);
            if (rd || wr)
               report_failure($sformatf("rd or wr high during reset in case %s", cur_name));
         end
         reset  <= 1'b0;
         active <= 1'b1;
         while (stores_seen < expected)
            @(negedge clock);
         active = 1'b0; // memory stays quiet until the next case is set up.
         if (exp_rd.size() != 0)
            report_failure($sformatf("case %s ended before all listed reads were seen",
                                     cur_name));
      end
      $display("TEST PASSED");
      $finish;
   end

endmodule
